//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and fixed register numbers
	//////////////////////////////////////////////////////////////////////

	localparam int dataWidth = 32;
	localparam int regBits = 5;
	// Link register for JAL
	localparam int raIndex = 31;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJal   = 6'h03;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opAndi  = 6'h0C;
	localparam logic [5:0] opOri   = 6'h0D;
	localparam logic [5:0] opLui   = 6'h0F;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnSlt = 6'h2A;

	// ALU operation select
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluLui,
		aluPassB
	} aluOpT;

	//////////////////////////////////////////////////////////////////////
	// Stream payloads and decoded instruction
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [dataWidth-1:0] word;
	} instrT;

	typedef struct packed {
		logic [regBits-1:0]   rs;
		logic [regBits-1:0]   rt;
		logic [regBits-1:0]   rdest;
		// 16-bit immediate, already extended to a full word
		logic [dataWidth-1:0] imm;
		aluOpT                aluOp;
		logic                 useImm;
		logic                 regWrite;
		logic                 raWrite;
	} decodedT;

	// Write-back record, wbDest of 0 means nothing written
	typedef struct packed {
		logic [regBits-1:0]   wbDest;
		logic [dataWidth-1:0] wbData;
		logic [dataWidth-1:0] wbSeq;
	} wbT;

endpackage

`default_nettype wire

//--- rtl/streamReg.sv
`timescale 1ns/100ps
`default_nettype none

module streamReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    sValid,
	output logic    sReady,
	input  payloadT sData,
	output logic    mValid,
	input  logic    mReady,
	output payloadT mData
);
	logic    full;
	// Holds ready low for the first cycle out of reset
	logic    readyEn;
	payloadT item;

	// Room when empty or when the held item leaves this cycle
	assign sReady = readyEn && (!full || mReady);
	assign mValid = full;
	assign mData  = item;

	// Control flags
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			readyEn <= 1'b0;
			full    <= 1'b0;
		end
		else
		begin
			readyEn <= 1'b1;
			// Not ready means full and stalled, so hold
			if (sReady)
				full <= sValid;
		end
	end

	// Payload, loaded on each input transfer
	always_ff @(posedge clk)
	begin
		if (sValid && sReady)
			item <= sData;
	end

endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
	input  cpuPkg::instrT   instr,
	output cpuPkg::decodedT dec
);
	import cpuPkg::*;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [15:0] imm16;

	// Standard MIPS field positions
	assign opcode = instr.word[31:26];
	assign funct  = instr.word[5:0];
	assign imm16  = instr.word[15:0];

	always_comb
	begin
		// Defaults give a NOP
		dec          = '0;
		dec.rs       = instr.word[25:21];
		dec.rt       = instr.word[20:16];
		dec.rdest    = instr.word[15:11];
		dec.aluOp    = aluAdd;
		case (opcode)
			opRType:
			begin
				dec.regWrite = 1'b1;
				case (funct)
					fnAdd: dec.aluOp = aluAdd;
					fnSub: dec.aluOp = aluSub;
					fnAnd: dec.aluOp = aluAnd;
					fnOr:  dec.aluOp = aluOr;
					fnXor: dec.aluOp = aluXor;
					fnSlt: dec.aluOp = aluSlt;
					// Unknown function, no write
					default: dec.regWrite = 1'b0;
				endcase
			end
			opAddi, opAndi, opOri, opLui:
			begin
				// I-type target is rt
				dec.rdest    = instr.word[20:16];
				dec.useImm   = 1'b1;
				dec.regWrite = 1'b1;
				dec.imm      = {16'h0000, imm16};
				case (opcode)
					opAddi:
					begin
						dec.aluOp = aluAdd;
						dec.imm   = {{16{imm16[15]}}, imm16};
					end
					opAndi:  dec.aluOp = aluAnd;
					opOri:   dec.aluOp = aluOr;
					default: dec.aluOp = aluLui;
				endcase
			end
			opJal:
			begin
				// Link goes through the return-address port
				dec.rdest   = 5'(raIndex);
				dec.aluOp   = aluPassB;
				dec.raWrite = 1'b1;
			end
			default:
			begin
				dec.regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile #(
	parameter int REGBITS = 5,
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rstN,
	input  logic               regWriteEn,
	input  logic               raWriteEn,
	input  logic [REGBITS-1:0] rs,
	input  logic [REGBITS-1:0] rt,
	input  logic [REGBITS-1:0] rdest,
	input  logic [WIDTH-1:0]   writeData,
	output logic [WIDTH-1:0]   rsData,
	output logic [WIDTH-1:0]   rtData
);
	import cpuPkg::*;

	localparam int numRegs = 1 << REGBITS;

	// Register array, 32 words by default
	logic [WIDTH-1:0] regs [numRegs];

	// Write on rising edge
	// General write wins over the link write
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end
		else if (regWriteEn)
		begin
			regs[rdest] <= writeData;
		end
		else if (raWriteEn)
		begin
			regs[REGBITS'(raIndex)] <= writeData;
		end
	end

	// Combinational reads
	// Index 0 is hardwired to zero
	assign rsData = (rs != '0) ? regs[rs] : '0;
	assign rtData = (rt != '0) ? regs[rt] : '0;

endmodule

`default_nettype wire

//--- alu/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit #(
	parameter int WIDTH = 32
) (
	input  cpuPkg::aluOpT     op,
	input  logic [WIDTH-1:0]  a,
	input  logic [WIDTH-1:0]  b,
	output logic [WIDTH-1:0]  result
);
	import cpuPkg::*;

	// Upper-immediate field width
	localparam int halfBits = 16;

	logic [WIDTH-1:0] sum;
	logic [WIDTH-1:0] diff;
	logic             lessSigned;
	logic [WIDTH-1:0] upperImm;

	//////////////////////////////////////////////////////////////////////
	// Shared arithmetic
	//////////////////////////////////////////////////////////////////////

	// Wrapping add and subtract, carries dropped
	assign sum  = a + b;
	assign diff = a - b;

	// Signed compare for SLT
	assign lessSigned = $signed(a) < $signed(b);

	// LUI puts the low half of b on top, zeros below
	assign upperImm = {b[halfBits-1:0], {(WIDTH - halfBits){1'b0}}};

	//////////////////////////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op)
			aluAdd:
				result = sum;
			aluSub:
				result = diff;
			aluAnd:
				result = a & b;
			aluOr:
				result = a | b;
			aluXor:
				result = a ^ b;
			aluSlt:
				result = {{(WIDTH - 1){1'b0}}, lessSigned};
			aluLui:
				result = upperImm;
			aluPassB:
				result = b;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/coreControl.sv
`timescale 1ns/100ps
`default_nettype none

module coreControl #(
	parameter int REGBITS = 5,
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rstN,
	input  logic               instrValid,
	output logic               instrReady,
	input  cpuPkg::decodedT    dec,
	output logic [REGBITS-1:0] rs,
	output logic [REGBITS-1:0] rt,
	output logic [REGBITS-1:0] rdest,
	output logic               regWriteEn,
	output logic               raWriteEn,
	output cpuPkg::aluOpT      aluOp,
	output logic [WIDTH-1:0]   operandB,
	output logic [WIDTH-1:0]   linkAddr,
	input  logic [WIDTH-1:0]   rsData,
	input  logic [WIDTH-1:0]   rtData,
	input  logic [WIDTH-1:0]   aluResult,
	output logic               wbValid,
	input  logic               wbReady,
	output cpuPkg::wbT         wbData
);
	import cpuPkg::*;

	typedef enum logic [1:0] {
		stIdle,
		stExecute,
		stEmit
	} stateT;

	stateT              state;
	decodedT            decReg;
	// Address of the next instruction to accept
	logic [WIDTH-1:0]   seqAddr;
	wbT                 wbReg;
	logic               writeGen;
	logic [REGBITS-1:0] wbDest;

	//////////////////////////////////////////////////////////////////////
	// Datapath controls from the held instruction
	//////////////////////////////////////////////////////////////////////

	assign rs    = decReg.rs;
	assign rt    = decReg.rt;
	assign rdest = decReg.rdest;
	assign aluOp = decReg.aluOp;

	// seqAddr already stepped past the held instruction
	assign linkAddr = seqAddr;

	// Operand B: immediate, link or rt
	assign operandB = decReg.useImm ? decReg.imm : (decReg.raWrite ? linkAddr : rtData);

	// Writes to register 0 are dropped
	assign writeGen   = decReg.regWrite && (decReg.rdest != '0);
	assign regWriteEn = (state == stExecute) && writeGen;
	assign raWriteEn  = (state == stExecute) && decReg.raWrite;

	// Destination reported in the record
	assign wbDest = writeGen ? decReg.rdest : (decReg.raWrite ? REGBITS'(raIndex) : '0);

	assign instrReady = (state == stIdle);
	assign wbValid    = (state == stEmit);
	assign wbData     = wbReg;

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state   <= stIdle;
			decReg  <= '0;
			seqAddr <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (instrValid)
					begin
						decReg  <= dec;
						seqAddr <= seqAddr + WIDTH'(4);
						state   <= stExecute;
					end
				end
				// Register write lands on this edge
				stExecute:
					state <= stEmit;
				// Wait for the output buffer
				stEmit:
				begin
					if (wbReady)
						state <= stIdle;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Record capture alongside the register write
	always_ff @(posedge clk)
	begin
		if (state == stExecute)
		begin
			wbReg.wbDest <= wbDest;
			wbReg.wbData <= aluResult;
			wbReg.wbSeq  <= seqAddr - WIDTH'(4);
		end
	end

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore #(
	parameter int REGBITS = cpuPkg::regBits,
	parameter int WIDTH = cpuPkg::dataWidth
) (
	input  logic          clk,
	input  logic          rstN,
	input  logic          inValid,
	output logic          inReady,
	input  cpuPkg::instrT inData,
	output logic          outValid,
	input  logic          outReady,
	output cpuPkg::wbT    outData
);
	import cpuPkg::*;

	// Input buffer to control
	logic               instrValid;
	logic               instrReady;
	instrT              instrWord;
	decodedT            dec;

	// Control to register file and ALU
	logic [REGBITS-1:0] rs;
	logic [REGBITS-1:0] rt;
	logic [REGBITS-1:0] rdest;
	logic               regWriteEn;
	logic               raWriteEn;
	aluOpT              aluOp;
	logic [WIDTH-1:0]   operandB;
	logic [WIDTH-1:0]   rsData;
	logic [WIDTH-1:0]   rtData;
	logic [WIDTH-1:0]   aluResult;

	// Control to output buffer
	logic               wbValid;
	logic               wbReady;
	wbT                 wbRec;

	//////////////////////////////////////////////////////////////////////
	// Stream buffers
	//////////////////////////////////////////////////////////////////////

	streamReg #(.payloadT(instrT)) inBuf (
		.clk    (clk),
		.rstN   (rstN),
		.sValid (inValid),
		.sReady (inReady),
		.sData  (inData),
		.mValid (instrValid),
		.mReady (instrReady),
		.mData  (instrWord)
	);

	streamReg #(.payloadT(wbT)) outBuf (
		.clk    (clk),
		.rstN   (rstN),
		.sValid (wbValid),
		.sReady (wbReady),
		.sData  (wbRec),
		.mValid (outValid),
		.mReady (outReady),
		.mData  (outData)
	);

	//////////////////////////////////////////////////////////////////////
	// Decode, control and datapath
	//////////////////////////////////////////////////////////////////////

	instrDecoder decoder (
		.instr (instrWord),
		.dec   (dec)
	);

	// Link address is folded into operandB inside control
	coreControl #(.REGBITS(REGBITS), .WIDTH(WIDTH)) control (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.dec        (dec),
		.rs         (rs),
		.rt         (rt),
		.rdest      (rdest),
		.regWriteEn (regWriteEn),
		.raWriteEn  (raWriteEn),
		.aluOp      (aluOp),
		.operandB   (operandB),
		.linkAddr   (),
		.rsData     (rsData),
		.rtData     (rtData),
		.aluResult  (aluResult),
		.wbValid    (wbValid),
		.wbReady    (wbReady),
		.wbData     (wbRec)
	);

	regFile #(.REGBITS(REGBITS), .WIDTH(WIDTH)) regs (
		.clk        (clk),
		.rstN       (rstN),
		.regWriteEn (regWriteEn),
		.raWriteEn  (raWriteEn),
		.rs         (rs),
		.rt         (rt),
		.rdest      (rdest),
		.writeData  (aluResult),
		.rsData     (rsData),
		.rtData     (rtData)
	);

	aluUnit #(.WIDTH(WIDTH)) alu (
		.op     (aluOp),
		.a      (rsData),
		.b      (operandB),
		.result (aluResult)
	);

endmodule

`default_nettype wire

//--- test/cpuCore_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCoreAssertions #(
	parameter int REGBITS = cpuPkg::regBits,
	parameter int WIDTH = cpuPkg::dataWidth
) (
	input logic               clk,
	input logic               rstN,
	input logic               inReady,
	input logic               outValid,
	input logic               outReady,
	input cpuPkg::wbT         outData,
	input logic [REGBITS-1:0] rs,
	input logic [REGBITS-1:0] rt,
	input logic [WIDTH-1:0]   rsData,
	input logic [WIDTH-1:0]   rtData
);
	// Read back by the testbench at the end of the run
	int failCount = 0;

	//////////////////////////////////////////////////////////////////////
	// Output stream handshake
	//////////////////////////////////////////////////////////////////////

	// Offered record stays put until taken
	outHold: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outData)))
	else
	begin
		failCount++;
		$error("outValid dropped or outData changed before the handshake");
	end

	// Both streams quiet while in reset
	resetQuiet: assert property (@(posedge clk)
		!rstN |-> (!inReady && !outValid))
	else
	begin
		failCount++;
		$error("inReady or outValid high during reset");
	end

	//////////////////////////////////////////////////////////////////////
	// Register 0 reads
	//////////////////////////////////////////////////////////////////////

	rsZero: assert property (@(posedge clk) disable iff (!rstN)
		(rs == '0) |-> (rsData == '0))
	else
	begin
		failCount++;
		$error("rs port read nonzero data for register 0");
	end

	rtZero: assert property (@(posedge clk) disable iff (!rstN)
		(rt == '0) |-> (rtData == '0))
	else
	begin
		failCount++;
		$error("rt port read nonzero data for register 0");
	end

endmodule

`default_nettype wire

//--- test/cpuCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;
	import cpuPkg::*;

	localparam int numRandom = 400;
	localparam int numDirected = 8;
	localparam int numInstr = numRandom + numDirected;
	// Three cycles per instruction, up to four more for stalls, plus margin
	localparam int cycleLimit = numInstr * 3 + numInstr * 4 + 200;

	// Predicted record, data unchecked for unknown instructions
	typedef struct packed {
		wbT   rec;
		logic checkData;
	} expectT;

	logic  clk;
	logic  rstN;
	logic  inValid;
	logic  inReady;
	instrT inData;
	logic  outValid;
	logic  outReady;
	wbT    outData;

	logic [31:0] stim [$];
	expectT      expQ [$];
	// Reference register state, r0 never written
	logic [31:0] modelRegs [32];
	logic [31:0] modelSeq;
	logic [31:0] lastSeq;
	logic        haveLast;
	// Set on an input handshake, cleared by the driver
	logic        inTaken;
	int          sentIdx;
	int          doneCount;
	int          valueErrors;
	int          protocolErrors;
	int          cycleCount;

	cpuCore #(.REGBITS(regBits), .WIDTH(dataWidth)) UUT (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inData),
		.outValid (outValid),
		.outReady (outReady),
		.outData  (outData)
	);

	bind cpuCore cpuCoreAssertions #(.REGBITS(REGBITS), .WIDTH(WIDTH)) assertChecks (
		.clk      (clk),
		.rstN     (rstN),
		.inReady  (inReady),
		.outValid (outValid),
		.outReady (outReady),
		.outData  (outData),
		.rs       (rs),
		.rt       (rt),
		.rsData   (rsData),
		.rtData   (rtData)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction builders
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] makeRType(logic [5:0] fn, logic [4:0] rsI,
		logic [4:0] rtI, logic [4:0] rdI);
		return {opRType, rsI, rtI, rdI, 5'd0, fn};
	endfunction

	function automatic logic [31:0] makeIType(logic [5:0] op, logic [4:0] rsI,
		logic [4:0] rtI, logic [15:0] imm);
		return {op, rsI, rtI, imm};
	endfunction

	function automatic logic [31:0] makeJal(logic [25:0] target);
		return {opJal, target};
	endfunction

	// Mostly a few hot registers so results get reused
	function automatic logic [4:0] pickReg();
		case ($urandom % 8)
			0: return 5'd0;
			1: return 5'd1;
			2: return 5'd2;
			3: return 5'd3;
			4: return 5'd4;
			5: return 5'd31;
			default: return 5'($urandom);
		endcase
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [15:0] imm;
		logic [5:0]  badOp;
		int          kind;
		imm  = 16'($urandom);
		kind = $urandom % 20;
		case ($urandom % 4)
			0: badOp = 6'h23;
			1: badOp = 6'h2B;
			2: badOp = 6'h04;
			default: badOp = 6'h3F;
		endcase
		case (kind)
			0, 1: return makeRType(fnAdd, pickReg(), pickReg(), pickReg());
			2: return makeRType(fnSub, pickReg(), pickReg(), pickReg());
			3: return makeRType(fnAnd, pickReg(), pickReg(), pickReg());
			4: return makeRType(fnOr, pickReg(), pickReg(), pickReg());
			5: return makeRType(fnXor, pickReg(), pickReg(), pickReg());
			6, 7: return makeRType(fnSlt, pickReg(), pickReg(), pickReg());
			8, 9: return makeIType(opAddi, pickReg(), pickReg(), imm);
			10: return makeIType(opAndi, pickReg(), pickReg(), imm);
			11: return makeIType(opOri, pickReg(), pickReg(), imm);
			12, 13: return makeIType(opLui, pickReg(), pickReg(), imm);
			14, 15: return makeJal(26'($urandom));
			// Unsupported opcode, NOP
			16: return {badOp, 26'($urandom)};
			// R-type with a funct the core lacks
			17: return makeRType(6'h00, pickReg(), pickReg(), pickReg());
			// Small negative ADDI for signed compares
			default: return makeIType(opAddi, pickReg(), pickReg(), {10'h3FF, 6'($urandom)});
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model and scoreboard
	//////////////////////////////////////////////////////////////////////

	task automatic predictInstr(input logic [31:0] word, output expectT exp);
		logic [5:0]  opc;
		logic [5:0]  fn;
		logic [4:0]  rsI;
		logic [4:0]  rtI;
		logic [4:0]  dest;
		logic [15:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic        known;
		opc   = word[31:26];
		fn    = word[5:0];
		rsI   = word[25:21];
		rtI   = word[20:16];
		imm   = word[15:0];
		a     = modelRegs[rsI];
		b     = modelRegs[rtI];
		res   = '0;
		dest  = '0;
		known = 1'b1;
		case (opc)
			opRType:
			begin
				dest = word[15:11];
				case (fn)
					fnAdd: res = a + b;
					fnSub: res = a - b;
					fnAnd: res = a & b;
					fnOr:  res = a | b;
					fnXor: res = a ^ b;
					fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: known = 1'b0;
				endcase
			end
			opAddi:
			begin
				dest = rtI;
				res  = a + {{16{imm[15]}}, imm};
			end
			opAndi:
			begin
				dest = rtI;
				res  = a & {16'h0000, imm};
			end
			opOri:
			begin
				dest = rtI;
				res  = a | {16'h0000, imm};
			end
			opLui:
			begin
				dest = rtI;
				res  = {imm, 16'h0000};
			end
			// Link is the next sequence address
			opJal:
			begin
				dest = 5'(raIndex);
				res  = modelSeq + 32'd4;
			end
			default:
				known = 1'b0;
		endcase
		if (!known)
			dest = '0;
		if (dest != '0)
			modelRegs[dest] = res;
		exp.rec.wbDest = dest;
		exp.rec.wbData = res;
		exp.rec.wbSeq  = modelSeq;
		exp.checkData  = known;
		modelSeq       = modelSeq + 32'd4;
	endtask

	task automatic checkRecord(input wbT rec);
		expectT exp;
		if (expQ.size() == 0)
		begin
			$display("Write-back record at %0t arrived with no instruction outstanding", $time);
			protocolErrors++;
		end
		else
		begin
			exp = expQ.pop_front();
			if (rec.wbSeq !== exp.rec.wbSeq)
			begin
				$display("[ERROR] %0t: wbSeq %h, expected %h", $time, rec.wbSeq, exp.rec.wbSeq);
				valueErrors++;
			end
			if (rec.wbDest !== exp.rec.wbDest)
			begin
				$display("[ERROR] %0t: wbDest %0d, expected %0d (seq %h)", $time,
					rec.wbDest, exp.rec.wbDest, exp.rec.wbSeq);
				valueErrors++;
			end
			if (exp.checkData && rec.wbData !== exp.rec.wbData)
			begin
				$display("[ERROR] %0t: wbData %h, expected %h (seq %h)", $time,
					rec.wbData, exp.rec.wbData, exp.rec.wbSeq);
				valueErrors++;
			end
			// Records come out in order, one step apart
			if (haveLast && rec.wbSeq !== lastSeq + 32'd4)
			begin
				$display("[ERROR] %0t: wbSeq %h does not follow %h", $time, rec.wbSeq, lastSeq);
				valueErrors++;
			end
			lastSeq  = rec.wbSeq;
			haveLast = 1'b1;
		end
	endtask

	// Handshakes sampled on the rising edge
	always @(posedge clk)
	begin
		expectT exp;
		if (rstN)
		begin
			if (inValid && inReady)
			begin
				predictInstr(inData.word, exp);
				expQ.push_back(exp);
				inTaken = 1'b1;
			end
			if (outValid && outReady)
			begin
				checkRecord(outData);
				doneCount++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and end of run
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(25));
		rstN           = 1'b0;
		inValid        = 1'b0;
		inData         = '0;
		outReady       = 1'b0;
		inTaken        = 1'b0;
		modelSeq       = '0;
		lastSeq        = '0;
		haveLast       = 1'b0;
		sentIdx        = 0;
		doneCount      = 0;
		valueErrors    = 0;
		protocolErrors = 0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;

		// Directed start: zero reads, link, r0 writes, NOP
		stim.push_back(makeRType(fnAdd, 5'd1, 5'd2, 5'd3));
		stim.push_back(makeRType(fnOr, 5'd5, 5'd6, 5'd4));
		stim.push_back(makeJal(26'h0000100));
		stim.push_back(makeRType(fnAdd, 5'd31, 5'd0, 5'd7));
		stim.push_back(makeIType(opAddi, 5'd1, 5'd0, 16'h1234));
		stim.push_back(makeRType(fnOr, 5'd0, 5'd0, 5'd8));
		stim.push_back(32'hFC00_0000);
		stim.push_back(makeRType(fnSub, 5'd0, 5'd31, 5'd9));
		for (int i = 0; i < numRandom; i++)
			stim.push_back(randomInstr());

		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Nothing offered yet, so no record either
		repeat (2)
		begin
			if (outValid !== 1'b0)
			begin
				$display("[ERROR] %0t: outValid high before any input", $time);
				valueErrors++;
			end
			@(negedge clk);
		end

		while (doneCount < numInstr)
		begin
			if (!inValid || inTaken)
			begin
				inTaken = 1'b0;
				// Gaps on roughly one cycle in four
				if (sentIdx < numInstr && ($urandom % 4) != 0)
				begin
					inValid     = 1'b1;
					inData.word = stim[sentIdx];
					sentIdx++;
				end
				else
					inValid = 1'b0;
			end
			outReady = ($urandom % 10) < 7;
			@(negedge clk);
		end

		// Drain window to catch extra records
		inValid  = 1'b0;
		outReady = 1'b1;
		repeat (10) @(negedge clk);
		if (expQ.size() != 0)
		begin
			$display("%0d predicted records never came out", expQ.size());
			protocolErrors++;
		end

		$display("Records %0d, value errors %0d, protocol errors %0d, assertion failures %0d",
			doneCount, valueErrors, protocolErrors, UUT.assertChecks.failCount);
		if (valueErrors == 0 && protocolErrors == 0 && UUT.assertChecks.failCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Run limit in clock cycles
	initial
	begin
		cycleCount = 0;
		wait (rstN === 1'b1);
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish in %0d cycles, %0d of %0d records seen",
			cycleLimit, doneCount, numInstr);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
common/cpuPkg.sv
rtl/streamReg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
alu/aluUnit.sv
rtl/coreControl.sv
rtl/cpuCore.sv
test/cpuCore_assertions.sv
test/cpuCoreTb.sv
